// File: Bender.yml
package:
  name: link_test

sources:
  - files:
      - src/link_pkg.sv
      - src/uart_tx.sv
      - src/uart_rx.sv
      - src/link_test_ctrl.sv
      - src/link_test_top.sv
  - target: test
    files:
      - bench/tb_link_test.sv

// File: bench/tb_link_test.sv
// Link test testbench
// Acts as the remote end of the serial link. Sends bytes from a table,
// collects the ACK replies on tx_line and checks LEDs and sync timing.

`timescale 1ns/1ps
`default_nettype none

module tb_link_test;
    import link_pkg::*;

    localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT;

    typedef struct packed {
        uart_byte_t data;
        logic       green;                      // Expected led_green
        logic       blue;                       // Expected led_blue
        bit         reply;                      // One ACK_BYTE expected
        bit         chain;                      // Next byte follows with no gap
    } step_t;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  rx_line;
    wire   tx_line;
    wire   sync_out;
    wire   led_red;
    wire   led_green;
    wire   led_blue;

    int    seed = 32'hd76a_46dc;
    int    errors = 0;
    int    frame_errs = 0;
    int    reply_cnt = 0;
    step_t steps[$];

    always #4 clk = ~clk;

    link_test_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_line   (rx_line),
        .tx_line   (tx_line),
        .sync_out  (sync_out),
        .led_red   (led_red),
        .led_green (led_green),
        .led_blue  (led_blue)
    );

    function automatic void add_step(uart_byte_t d, logic g, logic b, bit r, bit c);
        step_t s;
        s = '{data: d, green: g, blue: b, reply: r, chain: c};
        steps.push_back(s);
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_leds(input logic r, input logic g, input logic b);
        check_bit("led_red", r, led_red);
        check_bit("led_green", g, led_green);
        check_bit("led_blue", b, led_blue);
    endtask

    // 8N1 frame on rx_line sent LSB first
    task automatic send_byte(input uart_byte_t b);
        logic val;
        for (int i = 0; i < 10; i++) begin
            val = (i == 0) ? 1'b0 : (i == 9) ? 1'b1 : b[i-1];
            @(posedge clk);
            rx_line <= val;
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    // Start-up phase with LEDs dark and the line idle until the one-cycle sync pulse
    task automatic wait_sync();
        bit seen;
        seen = 0;
        for (int n = 0; n < STARTUP_CYCLES + 40 && !seen; n++) begin
            @(negedge clk);
            if (sync_out === 1'b1) begin
                seen = 1;
            end else begin
                check_leds(LED_OFF, LED_OFF, LED_OFF);
                check_bit("tx_line", 1'b1, tx_line);
            end
        end
        if (!seen) begin
            errors++;
            $display("Timeout: no sync_out pulse after the start-up delay at %0t", $time);
        end else begin
            @(negedge clk);
            check_bit("sync_out", 1'b0, sync_out);
        end
    endtask

    task automatic wait_replies(input int total);
        for (int n = 0; n < 8 * FRAME_CYCLES && reply_cnt < total; n++) begin
            @(negedge clk);
        end
        if (reply_cnt < total) begin
            errors++;
            $display("Timeout: ACK reply %0d never arrived on tx_line at %0t", total, $time);
        end
    endtask

    task automatic wait_leds(input logic r, input logic g, input logic b);
        bit hit;
        hit = 0;
        for (int n = 0; n < 4 * FRAME_CYCLES && !hit; n++) begin
            @(negedge clk);
            hit = (led_red === r) && (led_green === g) && (led_blue === b);
        end
        if (!hit) begin
            errors++;
            $display("Timeout: LEDs did not settle at %0t", $time);
        end
    endtask

    // Observation window long enough for an unwanted reply to show up
    task automatic expect_silence(input int total);
        repeat (15 * CLKS_PER_BIT) @(negedge clk);
        if (reply_cnt != total) begin
            errors++;
            $display("[FAIL] %0t reply_count expected %0d actual %0d", $time, total, reply_cnt);
        end
    endtask

    task automatic wait_window_end();
        bit done;
        done = 0;
        for (int n = 0; n < WINDOW_CYCLES + 40 && !done; n++) begin
            @(negedge clk);
            done = (led_blue === LED_OFF) && (led_red === LED_OFF);
        end
        if (!done) begin
            errors++;
            $display("Timeout: test window did not close at %0t", $time);
        end
    endtask

    // Serial monitor on the DUT's tx_line that samples mid-bit on the falling clock
    initial begin : tx_monitor
        uart_byte_t b;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && tx_line === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(negedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    b[i] = tx_line;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                if (tx_line !== 1'b1) begin
                    frame_errs++;
                    $display("Frame error: stop bit low on tx_line at %0t", $time);
                end else begin
                    reply_cnt++;
                    if (b !== ACK_BYTE) begin
                        errors++;
                        $display("[FAIL] %0t tx_byte expected %h actual %h", $time, ACK_BYTE, b);
                    end
                end
            end
        end
    end

    initial begin
        uart_byte_t bad;
        int         gap;
        int         exp_total;
        rst_n   = 1'b0;
        rx_line = 1'b1;

        bad = uart_byte_t'($random(seed));
        if (bad == TURN_ON || bad == TURN_OFF || bad == TOGGLE || bad == ACK_BYTE) begin
            bad = bad ^ 8'h01;                  // Flipped LSB is outside the code set
        end

        add_step(ACK_BYTE, LED_OFF, LED_ON,  0, 0);
        add_step(TURN_ON,  LED_ON,  LED_ON,  1, 0);
        add_step(TOGGLE,   LED_OFF, LED_ON,  1, 0);
        add_step(TOGGLE,   LED_ON,  LED_ON,  1, 0);
        add_step(TURN_OFF, LED_OFF, LED_ON,  1, 0);
        add_step(bad,      LED_OFF, LED_OFF, 0, 0);
        add_step(ACK_BYTE, LED_OFF, LED_ON,  0, 0);
        add_step(TURN_ON,  LED_ON,  LED_ON,  1, 1);     // Back to back pair
        add_step(TOGGLE,   LED_OFF, LED_ON,  1, 0);
        add_step(TURN_ON,  LED_ON,  LED_ON,  1, 0);     // Lamp left on when the window closes

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        wait_sync();
        check_leds(LED_ON, LED_OFF, LED_OFF);
        wait_replies(1);                        // Probe
        expect_silence(1);
        check_bit("led_red", LED_ON, led_red);
        exp_total = 1;

        for (int i = 0; i < steps.size(); i++) begin
            gap = $unsigned($random(seed)) % 21;
            if (i == 0 || !steps[i-1].chain) begin
                repeat (gap) @(posedge clk);
            end
            send_byte(steps[i].data);
            exp_total += steps[i].reply;
            if (!steps[i].chain) begin
                if (steps[i].reply) begin
                    wait_replies(exp_total);
                end else begin
                    wait_leds(!steps[i].blue, steps[i].green, steps[i].blue);
                    expect_silence(exp_total);
                end
                check_leds(!steps[i].blue, steps[i].green, steps[i].blue);
            end
        end
        if (frame_errs != 0) begin
            $display("Frame errors seen on tx_line during the command steps");
        end

        wait_window_end();
        check_leds(LED_OFF, LED_OFF, LED_OFF);

        // Second window starts with cleared flags, then the probe and an ACK back
        wait_sync();
        check_leds(LED_ON, LED_OFF, LED_OFF);
        wait_replies(exp_total + 1);
        send_byte(ACK_BYTE);
        wait_leds(LED_OFF, LED_OFF, LED_ON);
        check_leds(LED_OFF, LED_OFF, LED_ON);
        expect_silence(exp_total + 1);

        $display("Run complete: %0d errors, %0d frame errors, %0d replies",
                 errors, frame_errs, reply_cnt);
        if (errors == 0 && frame_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
src/link_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/link_test_ctrl.sv
src/link_test_top.sv
bench/tb_link_test.sv

// File: src/link_pkg.sv
// Link test shared definitions
// Byte type, command and reply codes, UART bit timing and the
// start-up and window lengths used by the link test controller.
// Also holds the state encodings of the UART and controller FSMs.

`default_nettype none

package link_pkg;

    // One serial data byte
    typedef logic [7:0] uart_byte_t;

    // Serial timing, 8 Mbaud from a 24 MHz clock
    localparam int CLKS_PER_BIT = 3;
    localparam int BIT_CNT_W    = 2;    // Must hold CLKS_PER_BIT - 1

    // Command and reply codes
    localparam uart_byte_t TURN_ON  = 8'hEE;
    localparam uart_byte_t TURN_OFF = 8'h55;
    localparam uart_byte_t TOGGLE   = 8'hC3;
    localparam uart_byte_t ACK_BYTE = 8'h33;

    // Controller timing, shortened for simulation
    localparam int STARTUP_CYCLES = 2400;
    localparam int WINDOW_CYCLES  = 6000;

    typedef logic [15:0] cycle_cnt_t;

    // LEDs on the board are active low
    localparam logic LED_ON  = 1'b0;
    localparam logic LED_OFF = 1'b1;

    typedef enum logic {
        ST_STARTUP,
        ST_WINDOW
    } ctrl_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage

`default_nettype wire

// File: src/link_test_ctrl.sv
// Link test controller
// Waits through a start-up delay, then opens a test window that starts
// with a sync pulse and an ACK probe. Received bytes are decoded into
// link status and lamp commands, commands are answered with ACK and the
// replies queue in a small pending counter. LEDs are active low.

`timescale 1ns/1ps
`default_nettype none

module link_test_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  link_pkg::uart_byte_t rx_data,
    input  logic                 rx_done,
    input  logic                 tx_busy,
    output logic                 tx_start,
    output link_pkg::uart_byte_t tx_data,
    output logic                 sync_out,
    output logic                 led_red,
    output logic                 led_green,
    output logic                 led_blue
);
    import link_pkg::*;

    ctrl_state_t state;
    cycle_cnt_t  cycle_cnt;
    logic        lamp_on;
    logic        link_good;
    logic [1:0]  pending;
    logic        in_window;
    logic        startup_done;
    logic        window_done;
    logic        is_cmd;
    logic        sched;
    logic        issue;

    assign in_window    = (state == ST_WINDOW);
    assign startup_done = !in_window && (cycle_cnt == cycle_cnt_t'(STARTUP_CYCLES - 1));
    assign window_done  = in_window && (cycle_cnt == cycle_cnt_t'(WINDOW_CYCLES - 1));

    assign is_cmd = (rx_data == TURN_ON) || (rx_data == TURN_OFF) || (rx_data == TOGGLE);

    // Probe at window open, one reply per command, dropped when the queue is full
    assign sched = (startup_done || (in_window && rx_done && is_cmd)) && (pending != 2'd3);
    // tx_busy lags tx_start by a cycle, so the strobe itself blocks the next one
    assign issue = (pending != 2'd0) && !tx_busy && !tx_start && !window_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_STARTUP;
            cycle_cnt <= '0;
            sync_out  <= 1'b0;
        end else begin
            sync_out <= startup_done;               // High in the first window cycle
            if (startup_done) begin
                state     <= ST_WINDOW;
                cycle_cnt <= '0;
            end else if (window_done) begin
                state     <= ST_STARTUP;
                cycle_cnt <= '0;
            end else begin
                cycle_cnt <= cycle_cnt + 1'b1;
            end
        end
    end

    // Byte decoder
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lamp_on   <= 1'b0;
            link_good <= 1'b0;
        end else if (window_done) begin
            lamp_on   <= 1'b0;
            link_good <= 1'b0;
        end else if (in_window && rx_done) begin
            case (rx_data)
                ACK_BYTE: link_good <= 1'b1;
                TURN_ON:  lamp_on   <= 1'b1;
                TURN_OFF: lamp_on   <= 1'b0;
                TOGGLE:   lamp_on   <= !lamp_on;
                default:  link_good <= 1'b0;        // Unknown byte means a bad link
            endcase
        end
    end

    // Reply queue
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending  <= 2'd0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= issue;
            if (window_done) begin
                pending <= 2'd0;
            end else begin
                case ({sched, issue})
                    2'b10:   pending <= pending + 1'b1;
                    2'b01:   pending <= pending - 1'b1;
                    default: pending <= pending;
                endcase
            end
        end
    end

    // Reply byte, loaded together with the start strobe
    always_ff @(posedge clk) begin
        if (issue) begin
            tx_data <= ACK_BYTE;
        end
    end

    assign led_red   = (in_window && !link_good) ? LED_ON : LED_OFF;
    assign led_blue  = (in_window && link_good) ? LED_ON : LED_OFF;
    assign led_green = (in_window && lamp_on) ? LED_ON : LED_OFF;

    a_sync_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        sync_out |=> !sync_out);

    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        tx_start |-> !tx_busy);

endmodule

`default_nettype wire

// File: src/link_test_top.sv
// Link test top level
// Connects the UART transmitter and receiver to the link test
// controller and brings the serial line, sync and LEDs to the board.

`timescale 1ns/1ps
`default_nettype none

module link_test_top (
    input  logic clk,
    input  logic rst_n,
    input  logic rx_line,
    output logic tx_line,
    output logic sync_out,
    output logic led_red,
    output logic led_green,
    output logic led_blue
);
    import link_pkg::*;

    uart_byte_t tx_data;
    uart_byte_t rx_data;
    logic       tx_start;
    logic       tx_busy;
    logic       rx_done;

    uart_tx u_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_line  (tx_line),
        .tx_busy  (tx_busy)
    );

    uart_rx u_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_line  (rx_line),
        .rx_data  (rx_data),
        .rx_done  (rx_done)
    );

    link_test_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_data   (rx_data),
        .rx_done   (rx_done),
        .tx_busy   (tx_busy),
        .tx_start  (tx_start),
        .tx_data   (tx_data),
        .sync_out  (sync_out),
        .led_red   (led_red),
        .led_green (led_green),
        .led_blue  (led_blue)
    );

endmodule

`default_nettype wire

// File: src/uart_rx.sv
// UART receiver
// Synchronizes the serial line, waits for a falling edge, re-checks
// the start bit at mid-bit and shifts in eight data bits LSB first.
// rx_done pulses in the middle of the stop bit when it samples high,
// otherwise the frame is dropped silently.

`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rx_line,
    output link_pkg::uart_byte_t rx_data,
    output logic                 rx_done
);
    import link_pkg::*;

    rx_state_t            state;
    logic                 rx_meta;
    logic                 rx_sync;
    logic                 rx_prev;
    logic                 fall_edge;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [2:0]           bit_idx;
    uart_byte_t           shift_reg;
    logic                 bit_end;
    logic                 mid_start;
    logic                 sample;
    logic                 frame_ok;

    // Two-flop synchronizer plus one stage for edge detection
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_line;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall_edge = rx_prev && !rx_sync;

    // The edge cycle is sample 0 of the start bit, so mid-bit is one count early
    assign mid_start = (bit_cnt == BIT_CNT_W'(CLKS_PER_BIT / 2 - 1));
    assign bit_end   = (bit_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));
    assign sample    = (state == RX_DATA) && bit_end;
    assign frame_ok  = (state == RX_STOP) && bit_end && rx_sync;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= RX_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
            rx_done <= 1'b0;
        end else begin
            rx_done <= frame_ok;
            case (state)
                RX_IDLE: begin
                    bit_cnt <= '0;
                    if (fall_edge) begin
                        state <= RX_START;
                    end
                end

                RX_START: begin
                    if (mid_start) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        // Glitch on the line, go back and wait for a real edge
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end

                RX_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                        bit_idx <= bit_idx + 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end

                RX_STOP: begin
                    if (bit_end) begin
                        bit_cnt <= '0;
                        state   <= RX_IDLE;     // Low stop bit drops the frame
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end

                default: state <= RX_IDLE;
            endcase
        end
    end

    // Received byte, held until the next good frame
    always_ff @(posedge clk) begin
        if (sample) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
        if (frame_ok) begin
            rx_data <= shift_reg;
        end
    end

    // Frames are far longer than a cycle, so done can never repeat back to back
    a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
        rx_done |=> !rx_done);

endmodule

`default_nettype wire

// File: src/uart_tx.sv
// UART transmitter
// Serializes one byte per start strobe, 8N1, LSB first.
// The line drops for the start bit one cycle after tx_start and
// tx_busy stays high for the full ten bit periods of the frame.

`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 tx_start,
    input  link_pkg::uart_byte_t tx_data,
    output logic                 tx_line,
    output logic                 tx_busy
);
    import link_pkg::*;

    tx_state_t            state;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [2:0]           bit_idx;
    uart_byte_t           shift_reg;
    logic                 bit_end;
    logic                 load;
    logic                 shift;

    assign bit_end = (bit_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));
    assign load    = (state == TX_IDLE) && tx_start;
    // Advance to the next data bit at the end of the start bit and of each data bit
    assign shift   = bit_end && ((state == TX_START) || (state == TX_DATA));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
            tx_line <= 1'b1;
            tx_busy <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    bit_cnt <= '0;
                    if (tx_start) begin
                        tx_line <= 1'b0;            // Start bit
                        tx_busy <= 1'b1;
                        state   <= TX_START;
                    end
                end

                TX_START: begin
                    if (bit_end) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        tx_line <= shift_reg[0];
                        state   <= TX_DATA;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end

                TX_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            tx_line <= 1'b1;        // Stop bit
                            state   <= TX_STOP;
                        end else begin
                            tx_line <= shift_reg[0];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end

                TX_STOP: begin
                    if (bit_end) begin
                        bit_cnt <= '0;
                        tx_busy <= 1'b0;
                        state   <= TX_IDLE;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end

                default: state <= TX_IDLE;
            endcase
        end
    end

    // Data path, bit 0 is always the next bit to go out
    always_ff @(posedge clk) begin
        if (load) begin
            shift_reg <= tx_data;
        end else if (shift) begin
            shift_reg <= {1'b0, shift_reg[7:1]};
        end
    end

    // A new byte while a frame is on the line would be lost
    a_no_start_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        tx_start |-> !tx_busy);

endmodule

`default_nettype wire
